//--- asym_fifo_top.f
design/asym_fifo_pkg.sv
design/banked_ram.sv
design/asym_width_converter.sv
design/asym_fifo_ctrl.sv
design/asym_fifo_top.sv
verification/asym_fifo_tb.sv

//--- verification/asym_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module asym_fifo_tb;

  import asym_fifo_pkg::*;

  // about twice the combined length of all tests
  localparam int MAX_CYCLES = 6000;
  localparam int MAX_RD_CREDITS = 4;
  localparam int RANDOM_CYCLES = 2500;

  logic    clk;
  logic    rst_n;
  wr_req_t wr;
  logic    r_credit;
  logic    w_credit;
  rd_rsp_t rd;

  // scoreboard, low byte of each word first
  logic [R_DATA_W-1:0] exp_q[$];

  int prod_credits;
  int rd_outstanding;
  int bytes_seen;
  int wcred_seen;
  int errors;
  int tests_passed;
  int tests_failed;
  int cycles;
  int seed;

  asym_fifo_top dut (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .wr_i       (wr),
    .w_credit_o (w_credit),
    .r_credit_i (r_credit),
    .rd_o       (rd)
  );

  always #4 clk = ~clk;

  // watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run went past %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_byte(input logic [R_DATA_W-1:0] got, input logic [R_DATA_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED rd_o.data: got 0x%02h, expected 0x%02h", got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (rd.valid) begin
        bytes_seen++;
        if (rd_outstanding == 0) begin
          errors++;
          $display("a byte came out without an outstanding read credit");
        end else begin
          rd_outstanding--;
        end
        if (exp_q.size() == 0) begin
          errors++;
          $display("a byte came out while the scoreboard was empty");
        end else begin
          check_byte(rd.data, exp_q.pop_front());
        end
      end
      if (w_credit) begin
        wcred_seen++;
        prod_credits++;
      end
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n    = 1'b0;
    wr       = '0;
    r_credit = 1'b0;
    exp_q.delete();
    prod_credits   = W_DEPTH;
    rd_outstanding = 0;
    bytes_seen     = 0;
    wcred_seen     = 0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  // one clock of producer and consumer activity
  task automatic drive_cycle(input logic wvalid, input logic [W_DATA_W-1:0] wdata,
                             input logic rcred);
    @(posedge clk);
    #1;
    if (wvalid && prod_credits == 0) begin
      errors++;
      $display("producer tried to write while holding no credit");
    end
    wr.valid = wvalid;
    wr.data  = wdata;
    r_credit = rcred;
    if (wvalid) begin
      prod_credits--;
      for (int lane = 0; lane < RATIO; lane++) begin
        exp_q.push_back(wdata[lane*R_DATA_W +: R_DATA_W]);
      end
    end
    if (rcred) begin
      rd_outstanding++;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, '0, 1'b0);
  endtask

  // hand out credits until every expected byte has left
  task automatic drain_fifo(input int limit);
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < limit) begin
      drive_cycle(1'b0, '0, (rd_outstanding < MAX_RD_CREDITS) &&
                            (rd_outstanding < exp_q.size()));
      waited++;
    end
    idle_cycles(4);
    if (exp_q.size() != 0) begin
      errors++;
      $display("drain stalled with %0d bytes still expected", exp_q.size());
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_passed++;
      $display("[%s] passed", name);
    end else begin
      tests_failed++;
      $display("[%s] failed with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic idle_after_reset();
    int errs_before;
    errs_before = errors;
    apply_reset();
    repeat (MAX_RD_CREDITS) drive_cycle(1'b0, '0, 1'b1);
    idle_cycles(20);
    check_count("bytes_seen", bytes_seen, 0);
    check_count("w_credit pulses", wcred_seen, 0);
    report_test("idle after reset", errs_before);
  endtask

  task automatic byte_order();
    int errs_before;
    errs_before = errors;
    apply_reset();
    drive_cycle(1'b1, 32'ha1b2_c3d4, 1'b0);
    repeat (RATIO) drive_cycle(1'b0, '0, 1'b1);
    drain_fifo(40);
    check_count("bytes_seen", bytes_seen, RATIO);
    check_count("w_credit pulses", wcred_seen, 1);
    report_test("byte order", errs_before);
  endtask

  task automatic fill_and_drain();
    int errs_before;
    logic [W_DATA_W-1:0] word;
    errs_before = errors;
    apply_reset();
    for (int i = 0; i < W_DEPTH; i++) begin
      // bytes count up 0..63 across the whole fill
      word = {8'(4*i + 3), 8'(4*i + 2), 8'(4*i + 1), 8'(4*i)};
      drive_cycle(1'b1, word, 1'b0);
    end
    idle_cycles(2);
    check_count("producer credits when full", prod_credits, 0);
    drain_fifo(200);
    check_count("bytes_seen", bytes_seen, W_DEPTH * RATIO);
    check_count("w_credit pulses", wcred_seen, W_DEPTH);
    check_count("producer credits", prod_credits, W_DEPTH);
    report_test("fill and drain", errs_before);
  endtask

  task automatic read_backpressure();
    int errs_before;
    int target;
    int waited;
    errs_before = errors;
    apply_reset();
    drive_cycle(1'b1, 32'h1122_3344, 1'b0);
    drive_cycle(1'b1, 32'h5566_7788, 1'b0);
    idle_cycles(50);
    check_count("bytes during stall", bytes_seen, 0);
    // single credits spaced apart, one byte each
    for (int n = 0; n < 2 * RATIO; n++) begin
      target = bytes_seen + 1;
      drive_cycle(1'b0, '0, 1'b1);
      waited = 0;
      while (bytes_seen < target && waited < 10) begin
        idle_cycles(1);
        waited++;
      end
      idle_cycles(6);
      check_count("bytes per credit", bytes_seen, target);
    end
    check_count("bytes left over", exp_q.size(), 0);
    check_count("w_credit pulses", wcred_seen, 2);
    report_test("read back-pressure", errs_before);
  endtask

  task automatic random_traffic();
    int errs_before;
    int burst_left;
    logic do_write;
    logic do_credit;
    errs_before = errors;
    apply_reset();
    seed = 36;
    burst_left = 0;
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      do_write = (prod_credits > 0) && ($random(seed) & 1);
      if (burst_left == 0 && ($random(seed) & 7) == 0) begin
        burst_left = ($random(seed) & 7) + 1;
      end
      do_credit = (burst_left > 0) && (rd_outstanding < MAX_RD_CREDITS);
      if (do_credit) begin
        burst_left--;
      end
      drive_cycle(do_write, $random(seed), do_credit);
    end
    drain_fifo(400);
    check_count("producer credits", prod_credits, W_DEPTH);
    check_count("outstanding read credits", rd_outstanding, 0);
    report_test("random traffic", errs_before);
  endtask

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    wr       = '0;
    r_credit = 1'b0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycles       = 0;
    idle_after_reset();
    byte_order();
    fill_and_drain();
    read_backpressure();
    random_traffic();
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/asym_fifo_top.sv
`timescale 1ns/1ps
`default_nettype none

module asym_fifo_top (
  input  wire                       clk_i,
  input  wire                       rst_n_i,
  // producer
  input  asym_fifo_pkg::wr_req_t    wr_i,
  output logic                      w_credit_o,
  // consumer
  input  wire                       r_credit_i,
  output asym_fifo_pkg::rd_rsp_t    rd_o
);

  import asym_fifo_pkg::*;

  logic                  w_en;
  logic [ROW_ADDR_W-1:0] w_addr;
  logic                  r_en;
  logic [R_ADDR_W-1:0]   r_addr;
  logic                  r_valid;
  logic [R_DATA_W-1:0]   r_data;
  ram_wr_t               ram_wr;
  ram_rd_t               ram_rd;
  mem_row_u              ram_data;

  // pointers, level and credit bookkeeping
  asym_fifo_ctrl u_ctrl (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wr_i       (wr_i),
    .w_credit_o (w_credit_o),
    .r_credit_i (r_credit_i),
    .r_valid_o  (r_valid),
    .w_en_o     (w_en),
    .w_addr_o   (w_addr),
    .r_en_o     (r_en),
    .r_addr_o   (r_addr)
  );

  // word-in, byte-out mapping onto the banks
  asym_width_converter u_conv (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .w_en_i     (w_en),
    .w_addr_i   (w_addr),
    .w_data_i   (wr_i.data),
    .r_en_i     (r_en),
    .r_addr_i   (r_addr),
    .ram_wr_o   (ram_wr),
    .ram_rd_o   (ram_rd),
    .ram_data_i (ram_data),
    .r_data_o   (r_data)
  );

  banked_ram u_ram (
    .clk_i      (clk_i),
    .ram_wr_i   (ram_wr),
    .ram_rd_i   (ram_rd),
    .ram_data_o (ram_data)
  );

  // valid from the controller, byte from the converter
  assign rd_o.valid = r_valid;
  assign rd_o.data  = r_data;

endmodule

`default_nettype wire

//--- design/asym_fifo_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module asym_fifo_ctrl (
  input  wire                                    clk_i,
  input  wire                                    rst_n_i,
  // producer side
  input  asym_fifo_pkg::wr_req_t                 wr_i,
  output logic                                   w_credit_o,
  // consumer side
  input  wire                                    r_credit_i,
  output logic                                   r_valid_o,
  // converter strobes and addresses
  output logic                                   w_en_o,
  output logic [asym_fifo_pkg::ROW_ADDR_W-1:0]   w_addr_o,
  output logic                                   r_en_o,
  output logic [asym_fifo_pkg::R_ADDR_W-1:0]     r_addr_o
);

  import asym_fifo_pkg::*;

  logic [ROW_ADDR_W-1:0] wr_ptr_q;
  logic [R_ADDR_W-1:0]   rd_ptr_q;
  logic [LEVEL_W-1:0]    level_q;
  logic [LEVEL_W-1:0]    level_nxt;
  logic [RCRED_W-1:0]    rcred_q;
  logic [RCRED_W-1:0]    rcred_nxt;
  logic                  rd_issue;
  logic                  last_lane;

  // producer only writes while it holds a credit, so no full check here
  assign w_en_o   = wr_i.valid;
  assign w_addr_o = wr_ptr_q;

  // a read needs both a consumer credit and a stored byte
  assign rd_issue = (rcred_q != '0) && (level_q != '0);
  assign r_en_o   = rd_issue;
  assign r_addr_o = rd_ptr_q;

  assign last_lane = (rd_ptr_q[LANE_SEL_W-1:0] == LANE_SEL_W'(RATIO - 1));

  // word write pointer
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
    end else if (w_en_o) begin
      wr_ptr_q <= wr_ptr_q + ROW_ADDR_W'(1);
    end
  end

  // byte read pointer, wraps with the word pointer
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
    end else if (rd_issue) begin
      rd_ptr_q <= rd_ptr_q + R_ADDR_W'(1);
    end
  end

  // byte level: up by a word on write, down by one on read
  always_comb begin
    level_nxt = level_q;
    if (w_en_o) begin
      level_nxt = level_nxt + LEVEL_W'(RATIO);
    end
    if (rd_issue) begin
      level_nxt = level_nxt - LEVEL_W'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      level_q <= '0;
    end else begin
      level_q <= level_nxt;
    end
  end

  // held read credits
  always_comb begin
    rcred_nxt = rcred_q;
    if (r_credit_i) begin
      rcred_nxt = rcred_nxt + RCRED_W'(1);
    end
    if (rd_issue) begin
      rcred_nxt = rcred_nxt - RCRED_W'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rcred_q <= '0;
    end else begin
      rcred_q <= rcred_nxt;
    end
  end

  // byte shows up one cycle after issue
  // a word credit goes back once lane 3 has been read
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_o  <= 1'b0;
      w_credit_o <= 1'b0;
    end else begin
      r_valid_o  <= rd_issue;
      w_credit_o <= rd_issue && last_lane;
    end
  end

endmodule

`default_nettype wire

//--- design/asym_width_converter.sv
`timescale 1ns/1ps
`default_nettype none

module asym_width_converter (
  input  wire                                     clk_i,
  input  wire                                     rst_n_i,
  // word write side
  input  wire                                     w_en_i,
  input  wire  [asym_fifo_pkg::ROW_ADDR_W-1:0]    w_addr_i,
  input  wire  [asym_fifo_pkg::W_DATA_W-1:0]      w_data_i,
  // byte read side
  input  wire                                     r_en_i,
  input  wire  [asym_fifo_pkg::R_ADDR_W-1:0]      r_addr_i,
  // banked ram port
  output asym_fifo_pkg::ram_wr_t                  ram_wr_o,
  output asym_fifo_pkg::ram_rd_t                  ram_rd_o,
  input  asym_fifo_pkg::mem_row_u                 ram_data_i,
  output logic [asym_fifo_pkg::R_DATA_W-1:0]      r_data_o
);

  import asym_fifo_pkg::*;

  logic [LANE_SEL_W-1:0] r_lane;
  logic [LANE_SEL_W-1:0] r_lane_q;
  logic                  r_data_valid_q;
  mem_row_u              row_hold_q;
  mem_row_u              row_sel;

  assign r_lane = r_addr_i[LANE_SEL_W-1:0];

  // write port: a whole word lands in every lane of one row
  always_comb begin
    ram_wr_o.lane_en  = {RATIO{w_en_i}};
    ram_wr_o.addr     = w_addr_i;
    ram_wr_o.row.word = w_data_i;
  end

  // read port: only the addressed lane fires
  always_comb begin
    ram_rd_o.lane_en = {{(RATIO - 1){1'b0}}, r_en_i} << r_lane;
    ram_rd_o.addr    = r_addr_i[R_ADDR_W-1:LANE_SEL_W];
  end

  // ram output is valid the cycle after a read
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_data_valid_q <= 1'b0;
    end else begin
      r_data_valid_q <= r_en_i;
    end
  end

  // lane select follows the read into the next cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_lane_q <= '0;
    end else if (r_en_i) begin
      r_lane_q <= r_lane;
    end
  end

  // keep the last row seen so the output byte stays stable
  always_ff @(posedge clk_i) begin
    if (r_data_valid_q) begin
      row_hold_q <= ram_data_i;
    end
  end

  // live row right after a read, held row otherwise
  always_comb begin
    if (r_data_valid_q) begin
      row_sel = ram_data_i;
    end else begin
      row_sel = row_hold_q;
    end
  end

  assign r_data_o = row_sel.lanes[r_lane_q];

endmodule

`default_nettype wire

//--- design/banked_ram.sv
`timescale 1ns/1ps
`default_nettype none

module banked_ram (
  input  wire                       clk_i,
  input  asym_fifo_pkg::ram_wr_t    ram_wr_i,
  input  asym_fifo_pkg::ram_rd_t    ram_rd_i,
  output asym_fifo_pkg::mem_row_u   ram_data_o
);

  import asym_fifo_pkg::*;

  mem_row_u rd_row_q;

  // one byte-wide bank per lane, all indexed by the same row
  for (genvar lane = 0; lane < RATIO; lane++) begin : g_bank
    logic [R_DATA_W-1:0] mem [W_DEPTH];

    always_ff @(posedge clk_i) begin
      if (ram_wr_i.lane_en[lane]) begin
        mem[ram_wr_i.addr] <= ram_wr_i.row.lanes[lane];
      end
    end

    // registered read, a disabled lane keeps its last value
    always_ff @(posedge clk_i) begin
      if (ram_rd_i.lane_en[lane]) begin
        rd_row_q.lanes[lane] <= mem[ram_rd_i.addr];
      end
    end
  end

  assign ram_data_o = rd_row_q;

endmodule

`default_nettype wire

//--- design/asym_fifo_pkg.sv
`default_nettype none

package asym_fifo_pkg;

  // write side is one full word, read side is one byte
  localparam int W_DATA_W = 32;
  localparam int R_DATA_W = 8;

  // bytes per word and the bits that pick one of them
  localparam int RATIO = W_DATA_W / R_DATA_W;
  localparam int LANE_SEL_W = $clog2(RATIO);

  // capacity in words, also the producer's starting credit count
  localparam int W_DEPTH = 16;
  localparam int ROW_ADDR_W = $clog2(W_DEPTH);

  // byte address is row address followed by lane select
  localparam int R_ADDR_W = ROW_ADDR_W + LANE_SEL_W;

  // byte count runs 0 to W_DEPTH * RATIO inclusive
  localparam int LEVEL_W = $clog2(W_DEPTH * RATIO) + 1;

  // consumer keeps at most four read credits outstanding
  localparam int RCRED_W = 3;

  typedef struct packed {
    logic                valid;
    logic [W_DATA_W-1:0] data;
  } wr_req_t;

  typedef struct packed {
    logic                valid;
    logic [R_DATA_W-1:0] data;
  } rd_rsp_t;

  // one ram row, seen as a word on writes and as byte lanes on reads
  typedef union packed {
    logic [W_DATA_W-1:0]              word;
    logic [RATIO-1:0][R_DATA_W-1:0]   lanes;
  } mem_row_u;

  typedef struct packed {
    logic [RATIO-1:0]      lane_en;
    logic [ROW_ADDR_W-1:0] addr;
    mem_row_u              row;
  } ram_wr_t;

  typedef struct packed {
    logic [RATIO-1:0]      lane_en;
    logic [ROW_ADDR_W-1:0] addr;
  } ram_rd_t;

endpackage

`default_nettype wire
